//--- compile.f
rtl/id_pkg.sv
rtl/decode_if.sv
rtl/bypass_if.sv
rtl/inst_decoder.sv
rtl/operand_mux.sv
rtl/id_ex_reg.sv
rtl/id_top.sv
testbench/id_chk.sv
testbench/id_tb.sv

//--- rtl/bypass_if.sv
`timescale 1ns/10ps

interface bypass_if import id_pkg::*; ();

    // execute stage write-back
    logic                  ex_wreg;
    logic [REG_ADDR_W-1:0] ex_wd;
    logic [WORD_W-1:0]     ex_wdata;

    // memory stage write-back
    logic                  mem_wreg;
    logic [REG_ADDR_W-1:0] mem_wd;
    logic [WORD_W-1:0]     mem_wdata;

    modport src (
        output ex_wreg, ex_wd, ex_wdata,
        output mem_wreg, mem_wd, mem_wdata
    );

    modport dst (
        input ex_wreg, ex_wd, ex_wdata,
        input mem_wreg, mem_wd, mem_wdata
    );

endinterface

//--- rtl/decode_if.sv
`timescale 1ns/10ps

interface decode_if import id_pkg::*; ();

    logic                  reg1_read;
    logic                  reg2_read;
    logic [REG_ADDR_W-1:0] reg1_addr;
    logic [REG_ADDR_W-1:0] reg2_addr;
    logic [WORD_W-1:0]     imm;
    logic [ALUOP_W-1:0]    aluop;
    logic [ALUSEL_W-1:0]   alusel;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  inst_valid;

    modport dec (
        output reg1_read, reg2_read, reg1_addr, reg2_addr, imm,
        output aluop, alusel, wd, wreg, inst_valid
    );

    // operand selection side
    modport sel (
        input reg1_read, reg2_read, reg1_addr, reg2_addr, imm
    );

    modport stg (
        input aluop, alusel, wd, wreg, inst_valid
    );

endinterface

//--- rtl/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    decode_if.stg                 dec,
    input  logic [WORD_W-1:0]     op1_i,
    input  logic [WORD_W-1:0]     op2_i,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [WORD_W-1:0]     ex_reg1_o,
    output logic [WORD_W-1:0]     ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic                  ex_inst_invalid_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_aluop_o        <= ALUOP_NOP;
            ex_alusel_o       <= SEL_NOP;
            ex_reg1_o         <= '0;
            ex_reg2_o         <= '0;
            ex_wd_o           <= NOP_REG_ADDR;
            ex_wreg_o         <= 1'b0;
            ex_inst_invalid_o <= 1'b0;
        end else if (!dec.inst_valid) begin
            // unknown instruction becomes a bubble
            ex_aluop_o        <= ALUOP_NOP;
            ex_alusel_o       <= SEL_NOP;
            ex_reg1_o         <= '0;
            ex_reg2_o         <= '0;
            ex_wd_o           <= NOP_REG_ADDR;
            ex_wreg_o         <= 1'b0;
            ex_inst_invalid_o <= 1'b1;
        end else begin
            ex_aluop_o        <= dec.aluop;
            ex_alusel_o       <= dec.alusel;
            ex_reg1_o         <= op1_i;
            ex_reg2_o         <= op2_i;
            ex_wd_o           <= dec.wd;
            ex_wreg_o         <= dec.wreg;
            ex_inst_invalid_o <= 1'b0;
        end
    end

endmodule

//--- rtl/id_pkg.sv
package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;

    localparam logic [REG_ADDR_W-1:0] NOP_REG_ADDR = '0;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;

    // function field under OP_SPECIAL
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // alu sub-operation
    localparam logic [ALUOP_W-1:0] ALUOP_NOP  = 8'b00000000;
    localparam logic [ALUOP_W-1:0] ALUOP_OR   = 8'b00100101;
    localparam logic [ALUOP_W-1:0] ALUOP_AND  = 8'b00100100;
    localparam logic [ALUOP_W-1:0] ALUOP_XOR  = 8'b00100110;
    localparam logic [ALUOP_W-1:0] ALUOP_NOR  = 8'b00100111;
    localparam logic [ALUOP_W-1:0] ALUOP_SLL  = 8'b01111100;
    localparam logic [ALUOP_W-1:0] ALUOP_SRL  = 8'b00000010;
    localparam logic [ALUOP_W-1:0] ALUOP_SRA  = 8'b00000011;
    localparam logic [ALUOP_W-1:0] ALUOP_ADD  = 8'b00100000;
    localparam logic [ALUOP_W-1:0] ALUOP_ADDU = 8'b00100001;
    localparam logic [ALUOP_W-1:0] ALUOP_SUB  = 8'b00100010;
    localparam logic [ALUOP_W-1:0] ALUOP_SUBU = 8'b00100011;
    localparam logic [ALUOP_W-1:0] ALUOP_SLT  = 8'b00101010;
    localparam logic [ALUOP_W-1:0] ALUOP_SLTU = 8'b00101011;

    // result class
    localparam logic [ALUSEL_W-1:0] SEL_NOP   = 3'b000;
    localparam logic [ALUSEL_W-1:0] SEL_LOGIC = 3'b001;
    localparam logic [ALUSEL_W-1:0] SEL_SHIFT = 3'b010;
    localparam logic [ALUSEL_W-1:0] SEL_ARITH = 3'b100;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fields_t;

    // one word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

endpackage

//--- rtl/id_top.sv
`timescale 1ns/10ps

module id_top import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [WORD_W-1:0]     inst_i,
    input  logic [WORD_W-1:0]     reg1_data_i,
    input  logic [WORD_W-1:0]     reg2_data_i,
    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [WORD_W-1:0]     ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [WORD_W-1:0]     mem_wdata_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic [REG_ADDR_W-1:0] reg1_addr_o,
    output logic [REG_ADDR_W-1:0] reg2_addr_o,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [WORD_W-1:0]     ex_reg1_o,
    output logic [WORD_W-1:0]     ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic                  ex_inst_invalid_o
);

    decode_if dec_bus ();
    bypass_if byp_bus ();

    logic [WORD_W-1:0] op1;
    logic [WORD_W-1:0] op2;

    // later-stage write-back buses
    assign byp_bus.ex_wreg   = ex_wreg_i;
    assign byp_bus.ex_wd     = ex_wd_i;
    assign byp_bus.ex_wdata  = ex_wdata_i;
    assign byp_bus.mem_wreg  = mem_wreg_i;
    assign byp_bus.mem_wd    = mem_wd_i;
    assign byp_bus.mem_wdata = mem_wdata_i;

    // register file read ports, same cycle
    assign reg1_read_o = dec_bus.reg1_read;
    assign reg2_read_o = dec_bus.reg2_read;
    assign reg1_addr_o = dec_bus.reg1_addr;
    assign reg2_addr_o = dec_bus.reg2_addr;

    inst_decoder i_inst_decoder (
        .inst_i (inst_i),
        .dec    (dec_bus.dec)
    );

    operand_mux i_operand_mux (
        .dec         (dec_bus.sel),
        .byp         (byp_bus.dst),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .op1_o       (op1),
        .op2_o       (op2)
    );

    id_ex_reg i_id_ex_reg (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .dec               (dec_bus.stg),
        .op1_i             (op1),
        .op2_i             (op2),
        .ex_aluop_o        (ex_aluop_o),
        .ex_alusel_o       (ex_alusel_o),
        .ex_reg1_o         (ex_reg1_o),
        .ex_reg2_o         (ex_reg2_o),
        .ex_wd_o           (ex_wd_o),
        .ex_wreg_o         (ex_wreg_o),
        .ex_inst_invalid_o (ex_inst_invalid_o)
    );

endmodule

//--- rtl/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import id_pkg::*; (
    input  inst_u inst_i,
    decode_if.dec dec
);

    logic [WORD_W-1:0] imm_zext;
    logic [WORD_W-1:0] imm_sext;
    logic [WORD_W-1:0] imm_upper;
    logic [WORD_W-1:0] imm_shamt;
    logic              r_form;
    logic              i_form;

    assign imm_zext  = {16'h0000, inst_i.i.imm16};
    assign imm_sext  = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
    assign imm_upper = {inst_i.i.imm16, 16'h0000};
    assign imm_shamt = {{(WORD_W - 5){1'b0}}, inst_i.r.shamt};

    always_comb begin
        dec.reg1_read  = 1'b0;
        dec.reg2_read  = 1'b0;
        dec.reg1_addr  = inst_i.r.rs;
        dec.reg2_addr  = inst_i.r.rt;
        dec.imm        = '0;
        dec.aluop      = ALUOP_NOP;
        dec.alusel     = SEL_NOP;
        dec.wd         = inst_i.r.rd;
        dec.wreg       = 1'b0;
        dec.inst_valid = 1'b0;
        r_form         = 1'b0;
        i_form         = 1'b1;

        case (inst_i.i.opcode)
            OP_SPECIAL: begin
                i_form = 1'b0;
                // register forms need a zero shamt field
                if (inst_i.r.shamt == 5'd0) begin
                    r_form = 1'b1;
                    case (inst_i.r.funct)
                        FN_OR:   {dec.aluop, dec.alusel} = {ALUOP_OR, SEL_LOGIC};
                        FN_AND:  {dec.aluop, dec.alusel} = {ALUOP_AND, SEL_LOGIC};
                        FN_XOR:  {dec.aluop, dec.alusel} = {ALUOP_XOR, SEL_LOGIC};
                        FN_NOR:  {dec.aluop, dec.alusel} = {ALUOP_NOR, SEL_LOGIC};
                        FN_SLLV: {dec.aluop, dec.alusel} = {ALUOP_SLL, SEL_SHIFT};
                        FN_SRLV: {dec.aluop, dec.alusel} = {ALUOP_SRL, SEL_SHIFT};
                        FN_SRAV: {dec.aluop, dec.alusel} = {ALUOP_SRA, SEL_SHIFT};
                        FN_ADD:  {dec.aluop, dec.alusel} = {ALUOP_ADD, SEL_ARITH};
                        FN_ADDU: {dec.aluop, dec.alusel} = {ALUOP_ADDU, SEL_ARITH};
                        FN_SUB:  {dec.aluop, dec.alusel} = {ALUOP_SUB, SEL_ARITH};
                        FN_SUBU: {dec.aluop, dec.alusel} = {ALUOP_SUBU, SEL_ARITH};
                        FN_SLT:  {dec.aluop, dec.alusel} = {ALUOP_SLT, SEL_ARITH};
                        FN_SLTU: {dec.aluop, dec.alusel} = {ALUOP_SLTU, SEL_ARITH};
                        default: r_form = 1'b0;
                    endcase
                end
            end
            OP_ORI: begin
                {dec.aluop, dec.alusel} = {ALUOP_OR, SEL_LOGIC};
                dec.imm = imm_zext;
            end
            OP_ANDI: begin
                {dec.aluop, dec.alusel} = {ALUOP_AND, SEL_LOGIC};
                dec.imm = imm_zext;
            end
            OP_XORI: begin
                {dec.aluop, dec.alusel} = {ALUOP_XOR, SEL_LOGIC};
                dec.imm = imm_zext;
            end
            OP_LUI: begin
                // or with rs, rs is r0 in real code
                {dec.aluop, dec.alusel} = {ALUOP_OR, SEL_LOGIC};
                dec.imm = imm_upper;
            end
            OP_ADDI: begin
                {dec.aluop, dec.alusel} = {ALUOP_ADD, SEL_ARITH};
                dec.imm = imm_sext;
            end
            OP_ADDIU: begin
                {dec.aluop, dec.alusel} = {ALUOP_ADDU, SEL_ARITH};
                dec.imm = imm_sext;
            end
            OP_SLTI: begin
                {dec.aluop, dec.alusel} = {ALUOP_SLT, SEL_ARITH};
                dec.imm = imm_sext;
            end
            OP_SLTIU: begin
                {dec.aluop, dec.alusel} = {ALUOP_SLTU, SEL_ARITH};
                dec.imm = imm_sext;
            end
            default: begin
                i_form = 1'b0;
            end
        endcase

        if (r_form) begin
            dec.reg1_read  = 1'b1;
            dec.reg2_read  = 1'b1;
            dec.wreg       = 1'b1;
            dec.inst_valid = 1'b1;
        end

        // i-type writes rt and reads rs only
        if (i_form) begin
            dec.reg1_read  = 1'b1;
            dec.wd         = inst_i.i.rt;
            dec.wreg       = 1'b1;
            dec.inst_valid = 1'b1;
        end

        // immediate shifts, opcode and rs all zero
        if ({inst_i.r.opcode, inst_i.r.rs} == 11'd0) begin
            if (inst_i.r.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                case (inst_i.r.funct)
                    FN_SLL:  dec.aluop = ALUOP_SLL;
                    FN_SRL:  dec.aluop = ALUOP_SRL;
                    default: dec.aluop = ALUOP_SRA;
                endcase
                dec.alusel     = SEL_SHIFT;
                dec.reg1_read  = 1'b0;
                dec.reg2_read  = 1'b1;
                dec.imm        = imm_shamt;
                dec.wd         = inst_i.r.rd;
                dec.wreg       = 1'b1;
                dec.inst_valid = 1'b1;
            end
        end
    end

endmodule

//--- rtl/operand_mux.sv
`timescale 1ns/10ps

module operand_mux import id_pkg::*; (
    decode_if.sel             dec,
    bypass_if.dst             byp,
    input  logic [WORD_W-1:0] reg1_data_i,
    input  logic [WORD_W-1:0] reg2_data_i,
    output logic [WORD_W-1:0] op1_o,
    output logic [WORD_W-1:0] op2_o
);

    // execute result first, then memory, then register file
    function automatic logic [WORD_W-1:0] resolve(
        input logic                  rd_en,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [WORD_W-1:0]     rf_data,
        input logic [WORD_W-1:0]     imm
    );
        logic [WORD_W-1:0] val;
        if (!rd_en) begin
            val = imm;
        end else if (byp.ex_wreg && (addr == byp.ex_wd)) begin
            val = byp.ex_wdata;
        end else if (byp.mem_wreg && (addr == byp.mem_wd)) begin
            val = byp.mem_wdata;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        op1_o = resolve(dec.reg1_read, dec.reg1_addr, reg1_data_i, dec.imm);
        op2_o = resolve(dec.reg2_read, dec.reg2_addr, reg2_data_i, dec.imm);
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the ID stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module id_tb -f compile.f -o id_sim
status=0
./obj_dir/id_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -eq 0 ] && grep -qx '>>> PASS' sim.log; then
    exit 0
fi
exit 1

//--- testbench/id_chk.sv
`timescale 1ns/10ps

module id_chk import id_pkg::*; (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic [ALUOP_W-1:0]    ex_aluop_o,
    input logic [REG_ADDR_W-1:0] ex_wd_o,
    input logic                  ex_wreg_o,
    input logic                  ex_inst_invalid_o
);

    int unsigned fail_cnt = 0;

    // a reset edge leaves no write and no invalid flag
    reset_flags: assert property (@(posedge clk) !rst_n_i |=> !ex_wreg_o && !ex_inst_invalid_o)
    else begin
        fail_cnt++;
        $error("write or invalid flag still set after a reset edge");
    end

    invalid_bubble: assert property (@(posedge clk)
        ex_inst_invalid_o |-> !ex_wreg_o && ex_aluop_o == ALUOP_NOP)
    else begin
        fail_cnt++;
        $error("invalid instruction left a write or a live alu operation");
    end

    reset_dest: assert property (@(posedge clk) !rst_n_i |=> ex_wd_o == NOP_REG_ADDR)
    else begin
        fail_cnt++;
        $error("destination not cleared by reset");
    end

endmodule

bind id_ex_reg id_chk i_id_chk (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .ex_aluop_o        (ex_aluop_o),
    .ex_wd_o           (ex_wd_o),
    .ex_wreg_o         (ex_wreg_o),
    .ex_inst_invalid_o (ex_inst_invalid_o)
);

//--- testbench/id_tb.sv
`timescale 1ns/10ps

module id_tb import id_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int STIM_DLY   = 2;
    localparam logic [31:0] LFSR_SEED = 32'd71162;

    localparam logic [5:0] R_FN [13] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV,
        FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    localparam logic [5:0] I_OP [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
        OP_SLTI, OP_SLTIU};

    typedef struct {
        logic                  rd1;
        logic                  rd2;
        logic [REG_ADDR_W-1:0] a1;
        logic [REG_ADDR_W-1:0] a2;
        logic [ALUOP_W-1:0]    aluop;
        logic [ALUSEL_W-1:0]   alusel;
        logic [WORD_W-1:0]     op1;
        logic [WORD_W-1:0]     op2;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic                  invalid;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [WORD_W-1:0]     inst;
    logic [WORD_W-1:0]     reg1_data;
    logic [WORD_W-1:0]     reg2_data;
    logic                  fwd_ex_wreg;
    logic [REG_ADDR_W-1:0] fwd_ex_wd;
    logic [WORD_W-1:0]     fwd_ex_wdata;
    logic                  fwd_mem_wreg;
    logic [REG_ADDR_W-1:0] fwd_mem_wd;
    logic [WORD_W-1:0]     fwd_mem_wdata;
    logic                  reg1_read;
    logic                  reg2_read;
    logic [REG_ADDR_W-1:0] reg1_addr;
    logic [REG_ADDR_W-1:0] reg2_addr;
    logic [ALUOP_W-1:0]    out_aluop;
    logic [ALUSEL_W-1:0]   out_alusel;
    logic [WORD_W-1:0]     out_op1;
    logic [WORD_W-1:0]     out_op2;
    logic [REG_ADDR_W-1:0] out_wd;
    logic                  out_wreg;
    logic                  out_invalid;

    logic [WORD_W-1:0] rf [32];
    logic [31:0]       lfsr;
    int                cyc = 0;
    int                checks = 0;
    int                errors = 0;
    int unsigned       afails;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // register file answers in the same cycle
    assign reg1_data = rf[reg1_addr];
    assign reg2_data = rf[reg2_addr];

    id_top i_id_top (
        .clk (clk), .rst_n_i (rst_n), .inst_i (inst),
        .reg1_data_i (reg1_data), .reg2_data_i (reg2_data),
        .ex_wreg_i (fwd_ex_wreg), .ex_wd_i (fwd_ex_wd), .ex_wdata_i (fwd_ex_wdata),
        .mem_wreg_i (fwd_mem_wreg), .mem_wd_i (fwd_mem_wd), .mem_wdata_i (fwd_mem_wdata),
        .reg1_read_o (reg1_read), .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr), .reg2_addr_o (reg2_addr),
        .ex_aluop_o (out_aluop), .ex_alusel_o (out_alusel),
        .ex_reg1_o (out_op1), .ex_reg2_o (out_op2), .ex_wd_o (out_wd),
        .ex_wreg_o (out_wreg), .ex_inst_invalid_o (out_invalid)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word();
        return rand_bits(32);
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rand_addr();
        logic [31:0] v;
        v = rand_bits(5);
        return v[4:0];
    endfunction

    function automatic logic [15:0] rand_half();
        logic [31:0] v;
        v = rand_bits(16);
        return v[15:0];
    endfunction

    function automatic logic [3:0] pick_rfn();
        logic [31:0] v;
        v = rand_bits(8) % 32'd13;
        return v[3:0];
    endfunction

    function automatic logic [WORD_W-1:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [WORD_W-1:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] k);
        return {op, rs, rt, k};
    endfunction

    // value a reading instruction should see for register a
    function automatic logic [WORD_W-1:0] source(input logic [REG_ADDR_W-1:0] a);
        if (fwd_ex_wreg && fwd_ex_wd == a)
            return fwd_ex_wdata;
        if (fwd_mem_wreg && fwd_mem_wd == a)
            return fwd_mem_wdata;
        return rf[a];
    endfunction

    function automatic exp_t model(input logic [WORD_W-1:0] w);
        exp_t              e;
        logic [5:0]        op;
        logic [5:0]        fn;
        logic [4:0]        rs;
        logic [4:0]        sh;
        logic [WORD_W-1:0] imm;
        op = w[31:26];
        rs = w[25:21];
        sh = w[10:6];
        fn = w[5:0];
        e = '{default: '0};
        e.a1 = rs;
        e.a2 = w[20:16];
        imm = '0;
        if (op == OP_SPECIAL) begin
            if (rs == 5'd0 && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)) begin
                e.aluop = (fn == FN_SLL) ? ALUOP_SLL : (fn == FN_SRL) ? ALUOP_SRL : ALUOP_SRA;
                e.alusel = SEL_SHIFT;
                e.rd2 = 1'b1;
                imm = {27'd0, sh};
            end else if (sh == 5'd0) begin
                case (fn)
                    FN_OR:   {e.aluop, e.alusel} = {ALUOP_OR, SEL_LOGIC};
                    FN_AND:  {e.aluop, e.alusel} = {ALUOP_AND, SEL_LOGIC};
                    FN_XOR:  {e.aluop, e.alusel} = {ALUOP_XOR, SEL_LOGIC};
                    FN_NOR:  {e.aluop, e.alusel} = {ALUOP_NOR, SEL_LOGIC};
                    FN_SLLV: {e.aluop, e.alusel} = {ALUOP_SLL, SEL_SHIFT};
                    FN_SRLV: {e.aluop, e.alusel} = {ALUOP_SRL, SEL_SHIFT};
                    FN_SRAV: {e.aluop, e.alusel} = {ALUOP_SRA, SEL_SHIFT};
                    FN_ADD:  {e.aluop, e.alusel} = {ALUOP_ADD, SEL_ARITH};
                    FN_ADDU: {e.aluop, e.alusel} = {ALUOP_ADDU, SEL_ARITH};
                    FN_SUB:  {e.aluop, e.alusel} = {ALUOP_SUB, SEL_ARITH};
                    FN_SUBU: {e.aluop, e.alusel} = {ALUOP_SUBU, SEL_ARITH};
                    FN_SLT:  {e.aluop, e.alusel} = {ALUOP_SLT, SEL_ARITH};
                    FN_SLTU: {e.aluop, e.alusel} = {ALUOP_SLTU, SEL_ARITH};
                    default: e.alusel = SEL_NOP;
                endcase
                e.rd1 = (e.alusel != SEL_NOP);
                e.rd2 = e.rd1;
            end
            e.wd = w[15:11];
        end else begin
            case (op)
                OP_ORI, OP_LUI: {e.aluop, e.alusel} = {ALUOP_OR, SEL_LOGIC};
                OP_ANDI:  {e.aluop, e.alusel} = {ALUOP_AND, SEL_LOGIC};
                OP_XORI:  {e.aluop, e.alusel} = {ALUOP_XOR, SEL_LOGIC};
                OP_ADDI:  {e.aluop, e.alusel} = {ALUOP_ADD, SEL_ARITH};
                OP_ADDIU: {e.aluop, e.alusel} = {ALUOP_ADDU, SEL_ARITH};
                OP_SLTI:  {e.aluop, e.alusel} = {ALUOP_SLT, SEL_ARITH};
                OP_SLTIU: {e.aluop, e.alusel} = {ALUOP_SLTU, SEL_ARITH};
                default:  e.alusel = SEL_NOP;
            endcase
            // lui fills the upper half, logic ops zero-extend, arithmetic sign-extends
            if (op == OP_LUI)
                imm = {w[15:0], 16'h0000};
            else if (e.alusel == SEL_LOGIC)
                imm = {16'h0000, w[15:0]};
            else
                imm = {{16{w[15]}}, w[15:0]};
            e.rd1 = (e.alusel != SEL_NOP);
            e.wd = w[20:16];
        end
        e.wreg = (e.alusel != SEL_NOP);
        e.invalid = !e.wreg;
        if (e.invalid) begin
            e.wd = '0;
        end else begin
            e.op1 = e.rd1 ? source(rs) : imm;
            e.op2 = e.rd2 ? source(w[20:16]) : imm;
        end
        return e;
    endfunction

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                              input logic [REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_aluop(input string name, input logic [ALUOP_W-1:0] got,
                               input logic [ALUOP_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_alusel(input string name, input logic [ALUSEL_W-1:0] got,
                                input logic [ALUSEL_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // polls off the edge, returns STIM_DLY after the n-th rising edge
    task automatic wait_cycles(input int n);
        int target;
        int guard;
        target = cyc + n;
        guard = 0;
        #0.5;
        while (cyc < target && guard < (n + 1) * CLK_PERIOD) begin
            #1;
            guard++;
        end
        if (cyc < target) begin
            errors++;
            $display("timeout: clock edge %0d not seen within %0d ns", target, guard);
        end else begin
            #(STIM_DLY - 0.5);
        end
    endtask

    task automatic set_bypass(input logic ew, input logic [4:0] ewd, input logic [31:0] ev,
                              input logic mw, input logic [4:0] mwd, input logic [31:0] mv);
        fwd_ex_wreg = ew;
        fwd_ex_wd = ewd;
        fwd_ex_wdata = ev;
        fwd_mem_wreg = mw;
        fwd_mem_wd = mwd;
        fwd_mem_wdata = mv;
    endtask

    task automatic check_reset_values();
        check_aluop("ex_aluop_o", out_aluop, ALUOP_NOP);
        check_alusel("ex_alusel_o", out_alusel, SEL_NOP);
        check_word("ex_reg1_o", out_op1, '0);
        check_word("ex_reg2_o", out_op2, '0);
        check_addr("ex_wd_o", out_wd, 5'd0);
        check_bit("ex_wreg_o", out_wreg, 1'b0);
        check_bit("ex_inst_invalid_o", out_invalid, 1'b0);
    endtask

    // read ports in the same cycle, stage outputs one edge later
    task automatic step(input logic [WORD_W-1:0] w);
        exp_t e;
        inst = w;
        e = model(w);
        #10;
        check_bit("reg1_read_o", reg1_read, e.rd1);
        check_bit("reg2_read_o", reg2_read, e.rd2);
        check_addr("reg1_addr_o", reg1_addr, e.a1);
        check_addr("reg2_addr_o", reg2_addr, e.a2);
        wait_cycles(1);
        check_aluop("ex_aluop_o", out_aluop, e.aluop);
        check_alusel("ex_alusel_o", out_alusel, e.alusel);
        check_word("ex_reg1_o", out_op1, e.op1);
        check_word("ex_reg2_o", out_op2, e.op2);
        check_addr("ex_wd_o", out_wd, e.wd);
        check_bit("ex_wreg_o", out_wreg, e.wreg);
        check_bit("ex_inst_invalid_o", out_invalid, e.invalid);
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        inst = enc_i(OP_ORI, 5'd1, 5'd2, 16'h00ff);
        wait_cycles(1);
        check_reset_values();
        wait_cycles(2);
        check_reset_values();
        rst_n = 1'b1;
    endtask

    task automatic test_reg_ops(input int n);
        set_bypass(1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
        for (int k = 0; k < n; k++)
            step(enc_r(R_FN[pick_rfn()], rand_addr(), rand_addr(), rand_addr(), 5'd0));
    endtask

    task automatic test_imm_forms();
        logic [2:0]  j;
        logic [15:0] k16;
        for (int k = 0; k < 16; k++) begin
            j = k[2:0];
            k16 = rand_half();
            k16[15] = k[3];
            step(enc_i(I_OP[j], rand_addr(), rand_addr(), k16));
        end
        for (int k = 0; k < 2; k++) begin
            step(enc_r(FN_SLL, 5'd0, rand_addr(), rand_addr(), rand_addr()));
            step(enc_r(FN_SRL, 5'd0, rand_addr(), rand_addr(), rand_addr()));
            step(enc_r(FN_SRA, 5'd0, rand_addr(), rand_addr(), rand_addr()));
        end
    endtask

    task automatic test_forwarding();
        logic [4:0]  a;
        logic [4:0]  b;
        logic [4:0]  d;
        logic [31:0] xv;
        logic [31:0] mv;
        for (int k = 0; k < 4; k++) begin
            a = rand_addr();
            b = rand_addr();
            d = rand_addr();
            xv = rand_word();
            mv = rand_word();
            set_bypass(1'b1, a, xv, 1'b0, a, mv);
            step(enc_r(FN_ADDU, a, b, d, 5'd0));
            set_bypass(1'b1, b, xv, 1'b1, b, mv);
            step(enc_r(FN_SUBU, a, b, d, 5'd0));
            set_bypass(1'b1, ~a, xv, 1'b1, a, mv);
            step(enc_r(FN_OR, a, b, d, 5'd0));
            set_bypass(1'b0, a, xv, 1'b0, b, mv);
            step(enc_r(FN_AND, a, b, d, 5'd0));
        end
        set_bypass(1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
    endtask

    task automatic bad_then_good(input logic [WORD_W-1:0] w);
        step(w);
        step(enc_r(FN_XOR, rand_addr(), rand_addr(), rand_addr(), 5'd0));
    endtask

    task automatic test_invalid();
        bad_then_good(enc_i(6'b100011, rand_addr(), rand_addr(), 16'h0004));
        bad_then_good(enc_i(6'b000010, rand_addr(), rand_addr(), rand_half()));
        bad_then_good(enc_i(6'b111111, rand_addr(), rand_addr(), rand_half()));
        bad_then_good(enc_r(6'b001000, rand_addr(), 5'd0, 5'd0, 5'd0));
        bad_then_good(enc_r(6'b011000, rand_addr(), rand_addr(), 5'd0, 5'd0));
        bad_then_good(enc_r(6'b001010, rand_addr(), rand_addr(), rand_addr(), 5'd0));
        // register add with a stray shift amount
        bad_then_good(enc_r(FN_ADD, rand_addr(), rand_addr(), rand_addr(), 5'd3));
    endtask

    task automatic test_stream(input int n);
        logic [31:0] v;
        for (int k = 0; k < n; k++) begin
            v = rand_bits(5);
            set_bypass(v[2], rand_addr(), rand_word(), v[3], rand_addr(), rand_word());
            case (v[1:0])
                2'd0: step(enc_r(R_FN[pick_rfn()], rand_addr(), rand_addr(), rand_addr(), 5'd0));
                2'd1: step(enc_i(I_OP[v[4:2]], rand_addr(), rand_addr(), rand_half()));
                2'd2: step(enc_r(FN_SRA, 5'd0, rand_addr(), rand_addr(), rand_addr()));
                default: step(enc_i(6'b101011, rand_addr(), rand_addr(), rand_half()));
            endcase
        end
    endtask

    initial begin
        rst_n = 1'b0;
        inst = '0;
        set_bypass(1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
        lfsr = LFSR_SEED;
        for (int k = 0; k < 32; k++)
            rf[k[4:0]] = rand_word();
        test_reset();
        test_reg_ops(24);
        test_imm_forms();
        test_forwarding();
        test_invalid();
        test_stream(32);
        afails = i_id_top.i_id_ex_reg.i_id_chk.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
